//--- hdl/align_params.svh
`ifndef ALIGN_PARAMS_SVH
`define ALIGN_PARAMS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Host word geometry
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define WIDTH      32  // Bits per host word
`define NUMVROW    96  // Words per bank
`define BITVROW    7
`define NUMVBNK    2   // Banks
`define BITVBNK    1

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Wide row geometry
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define NUMWRDS    3   // Words packed in one row, not a power of two
`define BITWRDS    2
`define NUMSROW    32  // Rows per bank
`define BITSROW    5
`define SEGW       16  // Bits under one segment enable
`define NUMSEG     6   // Segments across a row

// Latency and flop stages
`define SRAM_DELAY 2   // Memory read command to data
`define FLOPGEN    1   // Host input flop
`define FLOPOUT    1   // Read result flop

`endif

//--- hdl/align_pkg.sv
`include "align_params.svh"

package align_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Host side data
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef logic [`WIDTH-1:0] word_t;

  typedef logic [`WIDTH-1:0] mask_t;  // One bit per data bit, set to write

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Host side addressing
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef logic [`BITVROW-1:0] vaddr_t;  // Word address inside one bank

  typedef logic [`BITVBNK-1:0] bank_t;

  typedef logic [`BITWRDS-1:0] lane_t;  // Word position inside a row

  // Physical address of a read, lane in the upper bits and row below
  typedef logic [`BITWRDS+`BITSROW-1:0] padr_t;

endpackage

//--- hdl/mem_pkg.sv
`include "align_params.svh"

package mem_pkg;

  typedef logic [`NUMWRDS*`WIDTH-1:0] row_t;
  typedef logic [`NUMSEG-1:0]         dwsn_t;  // Low enables a segment
  typedef logic [`BITSROW-1:0]        srow_t;
  typedef logic [`BITVBNK-1:0]        mbank_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Segment enable helpers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic dwsn_t seg_dwsn(row_t bits);
    dwsn_t d;
    for (int s = 0; s < `NUMSEG; s++) begin
      d[s] = ~|bits[s*`SEGW +: `SEGW];  // Enabled when any bit of it is touched
    end
    return d;
  endfunction

  function automatic row_t seg_mask(dwsn_t d);
    row_t m;
    for (int s = 0; s < `NUMSEG; s++) begin
      m[s*`SEGW +: `SEGW] = {`SEGW{~d[s]}};
    end
    return m;
  endfunction

endpackage

//--- hdl/mem_if.sv
`timescale 1ns/10ps

interface mem_if;
  import mem_pkg::*;

  logic   write;
  mbank_t wr_bnk;
  srow_t  wr_adr;
  dwsn_t  wr_dwsn;
  row_t   bw;
  row_t   din;

  logic   read;
  mbank_t rd_bnk;
  srow_t  rd_adr;
  dwsn_t  rd_dwsn;
  row_t   rd_dout;  // Returns SRAM_DELAY cycles after read

  modport ctrl (output write, wr_bnk, wr_adr, wr_dwsn, bw, din,
                output read, rd_bnk, rd_adr, rd_dwsn,
                input  rd_dout);

  modport mem  (input  write, wr_bnk, wr_adr, wr_dwsn, bw, din,
                input  read, rd_bnk, rd_adr, rd_dwsn,
                output rd_dout);

  // Upstream face of a block that sits between a controller and the memory
  modport pass (input  write, wr_bnk, wr_adr, wr_dwsn, bw, din,
                input  read, rd_bnk, rd_adr, rd_dwsn,
                output rd_dout);

endinterface

//--- hdl/np2_addr.sv
`timescale 1ns/10ps
`include "align_params.svh"

module np2_addr (
  input  align_pkg::vaddr_t vaddr,
  output align_pkg::lane_t  lane,
  output mem_pkg::srow_t    row
);
  import align_pkg::*;
  import mem_pkg::*;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Word address to row and lane
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // NUMWRDS is not a power of two, so the split is a real divide by a constant.
  // Consecutive addresses walk across the lanes of one row before the row steps.

  localparam int NUMWRDS = `NUMWRDS;

  int unsigned quot;
  int unsigned rem;

  always_comb begin
    quot = int'(vaddr) / NUMWRDS;
    rem  = int'(vaddr) % NUMWRDS;
  end

  assign lane = lane_t'(rem);
  assign row  = srow_t'(quot);  // Fits, as NUMVROW equals NUMWRDS*NUMSROW

endmodule

//--- hdl/align_bw.sv
`timescale 1ns/10ps
`include "align_params.svh"

module align_bw (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              write,
  input  align_pkg::bank_t  wr_bnk,
  input  align_pkg::vaddr_t wr_adr,
  input  align_pkg::mask_t  bw,
  input  align_pkg::word_t  din,
  input  logic              read,
  input  align_pkg::bank_t  rd_bnk,
  input  align_pkg::vaddr_t rd_adr,
  output align_pkg::word_t  rd_dout,
  output logic              rd_fwrd,
  output align_pkg::padr_t  rd_padr,
  mem_if.ctrl               mem
);
  import align_pkg::*;
  import mem_pkg::*;

  localparam int TAIL = `SRAM_DELAY - 1;

  logic   write_s;
  logic   read_s;
  bank_t  wr_bnk_s;
  bank_t  rd_bnk_s;
  vaddr_t wr_adr_s;
  vaddr_t rd_adr_s;
  mask_t  bw_s;
  word_t  din_s;
  lane_t  wr_lane;
  lane_t  rd_lane;
  srow_t  wr_row;
  srow_t  rd_row;
  logic   fwd;
  row_t   wr_bw_row;
  lane_t  dl_lane [`SRAM_DELAY];
  srow_t  dl_row  [`SRAM_DELAY];
  mask_t  dl_fmsk [`SRAM_DELAY];
  word_t  dl_fdat [`SRAM_DELAY];
  word_t  tail_word;
  word_t  dout_nxt;
  logic   fwrd_nxt;
  padr_t  padr_nxt;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Host input stage
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  generate
    if (`FLOPGEN) begin : g_in_flop
      always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
          write_s <= 1'b0;
          read_s  <= 1'b0;
        end else begin
          write_s <= write;
          read_s  <= read;
        end
      end
      always_ff @(posedge clk) begin
        wr_bnk_s <= wr_bnk;
        wr_adr_s <= wr_adr;
        bw_s     <= bw;
        din_s    <= din;
        rd_bnk_s <= rd_bnk;
        rd_adr_s <= rd_adr;
      end
    end else begin : g_in_comb
      always_comb begin
        write_s  = write;
        read_s   = read;
        wr_bnk_s = wr_bnk;
        wr_adr_s = wr_adr;
        bw_s     = bw;
        din_s    = din;
        rd_bnk_s = rd_bnk;
        rd_adr_s = rd_adr;
      end
    end
  endgenerate

  np2_addr i_wr_np2 (.vaddr(wr_adr_s), .lane(wr_lane), .row(wr_row));
  np2_addr i_rd_np2 (.vaddr(rd_adr_s), .lane(rd_lane), .row(rd_row));

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Memory command
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign fwd       = read_s && write_s && (rd_bnk_s == wr_bnk_s) && (rd_adr_s == wr_adr_s);
  assign wr_bw_row = row_t'(bw_s) << (wr_lane * `WIDTH);

  assign mem.write   = write_s;
  assign mem.wr_bnk  = wr_bnk_s;
  assign mem.wr_adr  = wr_row;
  assign mem.wr_dwsn = seg_dwsn(wr_bw_row);  // Untouched segments stay disabled
  assign mem.bw      = wr_bw_row;
  assign mem.din     = row_t'(din_s) << (wr_lane * `WIDTH);
  assign mem.read    = read_s && !fwd;  // Served from the write data instead
  assign mem.rd_bnk  = rd_bnk_s;
  assign mem.rd_adr  = rd_row;
  assign mem.rd_dwsn = seg_dwsn(row_t'(mask_t'('1)) << (rd_lane * `WIDTH));

  // Read metadata travels alongside the memory access
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `SRAM_DELAY; i++) begin
        dl_fmsk[i] <= '0;
      end
    end else begin
      dl_fmsk[0] <= fwd ? bw_s : '0;
      for (int i = 1; i < `SRAM_DELAY; i++) begin
        dl_fmsk[i] <= dl_fmsk[i-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    dl_lane[0] <= rd_lane;
    dl_row[0]  <= rd_row;
    dl_fdat[0] <= din_s;
    for (int i = 1; i < `SRAM_DELAY; i++) begin
      dl_lane[i] <= dl_lane[i-1];
      dl_row[i]  <= dl_row[i-1];
      dl_fdat[i] <= dl_fdat[i-1];
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Lane select, merge and output stage
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign tail_word = word_t'(mem.rd_dout >> (dl_lane[TAIL] * `WIDTH));
  assign dout_nxt  = (dl_fmsk[TAIL] & dl_fdat[TAIL]) | (~dl_fmsk[TAIL] & tail_word);
  assign fwrd_nxt  = &dl_fmsk[TAIL];  // Only a full mask makes the whole word forwarded
  assign padr_nxt  = {dl_lane[TAIL], dl_row[TAIL]};

  generate
    if (`FLOPOUT) begin : g_out_flop
      always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
          rd_fwrd <= 1'b0;
        end else begin
          rd_fwrd <= fwrd_nxt;
        end
      end
      always_ff @(posedge clk) begin
        rd_dout <= dout_nxt;
        rd_padr <= padr_nxt;
      end
    end else begin : g_out_comb
      always_comb begin
        rd_dout = dout_nxt;
        rd_fwrd = fwrd_nxt;
        rd_padr = padr_nxt;
      end
    end
  endgenerate

endmodule

//--- hdl/mem_init_ctrl.sv
`timescale 1ns/10ps
`include "align_params.svh"

module mem_init_ctrl (
  input  logic clk,
  input  logic rst_n,
  output logic init_busy,
  mem_if.pass  up,
  mem_if.ctrl  dn
);
  import mem_pkg::*;

  localparam int CNTW = `BITVBNK + `BITSROW;
  localparam logic [CNTW-1:0] CNT_PRELAST = CNTW'(`NUMVBNK * `NUMSROW - 2);

  typedef enum logic [1:0] {CLEAR, LAST, RUN} state_t;

  state_t          state;
  state_t          state_nxt;
  logic [CNTW-1:0] sweep_cnt;  // Bank in the upper bits, row below

  always_comb begin
    state_nxt = state;
    case (state)
      CLEAR:   if (sweep_cnt == CNT_PRELAST) state_nxt = LAST;
      LAST:    state_nxt = RUN;
      default: state_nxt = RUN;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= CLEAR;
      sweep_cnt <= '0;
    end else begin
      state <= state_nxt;
      if (state != RUN) sweep_cnt <= sweep_cnt + 1'b1;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Command mux toward the memory
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    dn.write   = up.write;
    dn.wr_bnk  = up.wr_bnk;
    dn.wr_adr  = up.wr_adr;
    dn.wr_dwsn = up.wr_dwsn;
    dn.bw      = up.bw;
    dn.din     = up.din;
    dn.read    = up.read;
    dn.rd_bnk  = up.rd_bnk;
    dn.rd_adr  = up.rd_adr;
    dn.rd_dwsn = up.rd_dwsn;
    if (state != RUN) begin
      dn.write   = 1'b1;  // Clear one row per cycle
      dn.wr_bnk  = mbank_t'(sweep_cnt >> `BITSROW);
      dn.wr_adr  = srow_t'(sweep_cnt);
      dn.wr_dwsn = '0;
      dn.bw      = '1;
      dn.din     = '0;
      dn.read    = 1'b0;
    end
  end

  assign up.rd_dout = dn.rd_dout;
  assign init_busy  = (state != RUN);

endmodule

//--- hdl/banked_sram.sv
`timescale 1ns/10ps
`include "align_params.svh"

module banked_sram (
  input logic clk,
  input logic rst_n,
  mem_if.mem  port
);
  import mem_pkg::*;

  row_t ram [`NUMVBNK][`NUMSROW];
  row_t wmask;
  row_t rd_pipe [`SRAM_DELAY];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Write port
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // A bit is written only when its segment is enabled and its bw bit is set
  assign wmask = port.bw & seg_mask(port.wr_dwsn);

  always_ff @(posedge clk) begin
    if (port.write) begin
      ram[port.wr_bnk][port.wr_adr] <= (ram[port.wr_bnk][port.wr_adr] & ~wmask) |
                                       (port.din & wmask);
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Read port
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `SRAM_DELAY; i++) begin
        rd_pipe[i] <= '0;
      end
    end else begin
      rd_pipe[0] <= port.read ? (ram[port.rd_bnk][port.rd_adr] & seg_mask(port.rd_dwsn)) : '0;
      for (int i = 1; i < `SRAM_DELAY; i++) begin
        rd_pipe[i] <= rd_pipe[i-1];
      end
    end
  end

  assign port.rd_dout = rd_pipe[`SRAM_DELAY-1];  // Old row when read and write collide

endmodule

//--- hdl/align_mem_top.sv
`timescale 1ns/10ps

module align_mem_top (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              write,
  input  align_pkg::bank_t  wr_bnk,
  input  align_pkg::vaddr_t wr_adr,
  input  align_pkg::mask_t  bw,
  input  align_pkg::word_t  din,
  input  logic              read,
  input  align_pkg::bank_t  rd_bnk,
  input  align_pkg::vaddr_t rd_adr,
  output align_pkg::word_t  rd_dout,
  output logic              rd_fwrd,
  output align_pkg::padr_t  rd_padr,
  output logic              init_busy
);

  mem_if up_if ();  // Aligner to init controller
  mem_if dn_if ();  // Init controller to memory

  align_bw i_align_bw (
    .clk     (clk),
    .rst_n   (rst_n),
    .write   (write),
    .wr_bnk  (wr_bnk),
    .wr_adr  (wr_adr),
    .bw      (bw),
    .din     (din),
    .read    (read),
    .rd_bnk  (rd_bnk),
    .rd_adr  (rd_adr),
    .rd_dout (rd_dout),
    .rd_fwrd (rd_fwrd),
    .rd_padr (rd_padr),
    .mem     (up_if.ctrl)
  );

  mem_init_ctrl i_mem_init_ctrl (
    .clk       (clk),
    .rst_n     (rst_n),
    .init_busy (init_busy),
    .up        (up_if.pass),
    .dn        (dn_if.ctrl)
  );

  banked_sram i_banked_sram (.clk(clk), .rst_n(rst_n), .port(dn_if.mem));

endmodule

//--- sim/align_props.sv
`timescale 1ns/10ps

module align_props (
  input logic clk,
  input logic rst_n,
  input logic write,
  input logic read,
  input logic init_busy,
  input logic dn_read,
  input logic rd_fwrd
);

  logic failed = 1'b0;  // Sticky once any property fails

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Init sequence
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  a_no_cmd_in_init: assert property (@(posedge clk) disable iff (!rst_n)
    init_busy |-> !(write || read))
    else begin
      failed = 1'b1;
      $error("Host command issued while init_busy is high");
    end

  // init_busy spans CLEAR and LAST, and the sweep owns the memory port in both
  a_no_mem_read_in_clear: assert property (@(posedge clk) disable iff (!rst_n)
    init_busy |-> !dn_read)
    else begin
      failed = 1'b1;
      $error("Memory read issued during the clear sweep");
    end

  a_fwrd_known: assert property (@(posedge clk) disable iff (!rst_n)
    !$isunknown(rd_fwrd))
    else begin
      failed = 1'b1;
      $error("rd_fwrd is unknown after reset");
    end

endmodule

//--- sim/align_tb.sv
`timescale 1ns/10ps
`include "align_params.svh"

module align_tb;
  import align_pkg::*;

  localparam int CLK_PERIOD  = 20;
  localparam int INIT_CYCLES = `NUMVBNK * `NUMSROW;
  localparam int INIT_READS  = 10;
  localparam int RT_OPS      = 24;
  localparam int PART_OPS    = 11;
  localparam int FWD_OPS     = 6;
  localparam int RAND_OPS    = 200;
  localparam int DRAIN       = 8;  // Per test, covers the read latency and some slack
  localparam int TEST_CYCLES = 5 + INIT_READS + RT_OPS + PART_OPS + FWD_OPS + RAND_OPS + 5 * DRAIN;
  localparam int WATCHDOG_CYCLES = INIT_CYCLES + 20 + TEST_CYCLES;

  typedef struct packed {
    int     due;
    word_t  data;
    mask_t  msk;
    logic   fwrd;
    padr_t  padr;
    bank_t  bnk;
    vaddr_t adr;
  } exp_t;

  logic   clk;
  logic   rst_n;
  logic   write;
  bank_t  wr_bnk;
  vaddr_t wr_adr;
  mask_t  bw;
  word_t  din;
  logic   read;
  bank_t  rd_bnk;
  vaddr_t rd_adr;
  word_t  rd_dout;
  logic   rd_fwrd;
  padr_t  rd_padr;
  logic   init_busy;

  word_t       model [`NUMVBNK][`NUMVROW];
  exp_t        exp_q [$];
  exp_t        head;
  int          edge_cnt;
  logic [31:0] rng_state;
  logic        init_done;
  logic        pend_wr;  // Write issued this cycle, enters the model at the next tick
  bank_t       pend_bnk;
  vaddr_t      pend_adr;
  mask_t       pend_msk;
  word_t       pend_dat;

  align_mem_top i_align_mem_top (
    .clk       (clk),
    .rst_n     (rst_n),
    .write     (write),
    .wr_bnk    (wr_bnk),
    .wr_adr    (wr_adr),
    .bw        (bw),
    .din       (din),
    .read      (read),
    .rd_bnk    (rd_bnk),
    .rd_adr    (rd_adr),
    .rd_dout   (rd_dout),
    .rd_fwrd   (rd_fwrd),
    .rd_padr   (rd_padr),
    .init_busy (init_busy)
  );

  bind align_mem_top align_props i_align_props (
    .clk       (clk),
    .rst_n     (rst_n),
    .write     (write),
    .read      (read),
    .init_busy (init_busy),
    .dn_read   (dn_if.read),
    .rd_fwrd   (rd_fwrd)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk = ~clk;
    end
  end

  always @(posedge clk) begin
    edge_cnt <= edge_cnt + 1;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Reporting and compare tasks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  task automatic check_word(input word_t act, input word_t exp, input mask_t msk,
                            input string what);
    if (((act ^ exp) & msk) !== '0) begin
      abort_run($sformatf("CHECK FAILED at %0t: %s, got %h, expected %h under mask %h",
                          $time, what, act, exp, msk));
    end
  endtask

  task automatic check_padr(input padr_t act, input padr_t exp, input string what);
    if (act !== exp) begin
      abort_run($sformatf("CHECK FAILED at %0t: %s, got %h, expected %h",
                          $time, what, act, exp));
    end
  endtask

  task automatic check_flag(input logic act, input logic exp, input string what);
    if (act !== exp) begin
      abort_run($sformatf("CHECK FAILED at %0t: %s, got %b, expected %b",
                          $time, what, act, exp));
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Reference model and stimulus
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  function automatic logic [31:0] xorshift32();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // Lane above row, with lane the address modulo the words per row
  function automatic padr_t expect_padr(input vaddr_t adr);
    lane_t               lane;
    logic [`BITSROW-1:0] row;
    lane = lane_t'(int'(adr) % `NUMWRDS);
    row  = (`BITSROW)'(int'(adr) / `NUMWRDS);
    return {lane, row};
  endfunction

  task automatic tick();
    if (pend_wr) begin
      model[pend_bnk][pend_adr] = (model[pend_bnk][pend_adr] & ~pend_msk) |
                                  (pend_dat & pend_msk);
    end
    pend_wr = 1'b0;
    @(posedge clk);
    write <= 1'b0;
    read  <= 1'b0;
  endtask

  task automatic do_write(input bank_t b, input vaddr_t a, input mask_t m, input word_t d);
    write    <= 1'b1;
    wr_bnk   <= b;
    wr_adr   <= a;
    bw       <= m;
    din      <= d;
    pend_wr  = 1'b1;
    pend_bnk = b;
    pend_adr = a;
    pend_msk = m;
    pend_dat = d;
  endtask

  task automatic do_read(input bank_t b, input vaddr_t a);
    exp_t e;
    read   <= 1'b1;
    rd_bnk <= b;
    rd_adr <= a;
    e.due  = edge_cnt + 5;  // Sampled at the next edge, result out three edges after that
    e.bnk  = b;
    e.adr  = a;
    e.padr = expect_padr(a);
    if (pend_wr && pend_bnk == b && pend_adr == a) begin
      e.data = pend_dat;  // Same-cycle write is forwarded
      e.msk  = pend_msk;
      e.fwrd = (pend_msk == '1);
    end else begin
      e.data = model[b][a];
      e.msk  = '1;
      e.fwrd = 1'b0;
    end
    exp_q.push_back(e);
  endtask

  task automatic drain();
    tick();
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
  endtask

  always @(negedge clk) begin
    if (exp_q.size() != 0 && exp_q[0].due == edge_cnt) begin
      head = exp_q.pop_front();
      check_word(rd_dout, head.data, head.msk,
                 $sformatf("rd_dout of bank %0d addr %0d", head.bnk, head.adr));
      check_flag(rd_fwrd, head.fwrd,
                 $sformatf("rd_fwrd of bank %0d addr %0d", head.bnk, head.adr));
      check_padr(rd_padr, head.padr,
                 $sformatf("rd_padr of bank %0d addr %0d", head.bnk, head.adr));
    end
    if (init_done && init_busy !== 1'b0) begin
      abort_run("init_busy rose again after the memory clear had finished");
    end
    if (i_align_mem_top.i_align_props.failed === 1'b1) begin
      abort_run("A concurrent assertion in align_props failed");
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Directed tests
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic test_init();
    int n;
    n = 0;
    while (init_busy !== 1'b0) begin
      @(negedge clk);
      n++;
      // The first negedge falls half a cycle after release
      if (n > INIT_CYCLES && init_busy !== 1'b0) begin
        abort_run($sformatf("init_busy still high %0d cycles after reset release",
                            INIT_CYCLES));
      end
    end
    init_done = 1'b1;
    for (int i = 0; i < INIT_READS; i++) begin
      tick();
      do_read(bank_t'(i % 2), vaddr_t'((i * 37) % `NUMVROW));  // Cleared rows read zero
    end
    drain();
  endtask

  task automatic test_round_trip();
    int addrs [6] = '{0, 1, 2, 43, 47, 93};  // Every lane, first and last rows
    for (int b = 0; b < `NUMVBNK; b++) begin
      for (int i = 0; i < 6; i++) begin
        tick();
        do_write(bank_t'(b), vaddr_t'(addrs[i]), '1, xorshift32());
      end
    end
    for (int b = 0; b < `NUMVBNK; b++) begin
      for (int i = 0; i < 6; i++) begin
        tick();
        do_read(bank_t'(b), vaddr_t'(addrs[i]));
      end
    end
    drain();
  endtask

  task automatic test_partial();
    for (int i = 0; i < 3; i++) begin
      tick();
      do_write(1'b1, vaddr_t'(30 + i), '1, xorshift32());  // All three lanes of row 10
    end
    tick();
    do_write(1'b1, 7'd30, 32'h0000_ffff, xorshift32());  // Upper segment untouched
    tick();
    do_write(1'b1, 7'd31, 32'hff00_00ff, xorshift32());
    tick();
    do_write(1'b1, 7'd32, 32'h8000_0001, xorshift32());
    tick();
    do_write(1'b1, 7'd31, '0, xorshift32());
    tick();
    do_write(1'b1, 7'd32, xorshift32(), xorshift32());
    for (int i = 0; i < 3; i++) begin
      tick();
      do_read(1'b1, vaddr_t'(30 + i));
    end
    drain();
  endtask

  task automatic test_forward();
    tick();
    do_write(1'b0, 7'd7, '1, xorshift32());
    do_read(1'b0, 7'd7);
    tick();
    do_write(1'b1, 7'd8, 32'h00ff_00ff, xorshift32());
    do_read(1'b1, 7'd8);
    tick();
    do_write(1'b0, 7'd18, '1, xorshift32());
    do_read(1'b0, 7'd19);  // Same row, other lane, so no forwarding
    tick();
    do_read(1'b0, 7'd7);
    tick();
    do_read(1'b1, 7'd8);
    tick();
    do_read(1'b0, 7'd18);
    drain();
  endtask

  task automatic test_random();
    logic [31:0] r;
    bank_t       wb;
    vaddr_t      wa;
    mask_t       wm;
    for (int i = 0; i < RAND_OPS; i++) begin
      r  = xorshift32();
      wb = bank_t'(r[0]);
      wa = vaddr_t'(r[15:8] % `NUMVROW);
      tick();
      if (r[1]) begin
        wm = r[2] ? '1 : mask_t'(xorshift32());
        do_write(wb, wa, wm, xorshift32());
      end
      if (r[4:3] == 2'b00) begin
        do_read(wb, wa);  // Collides with the write when there is one
      end else begin
        do_read(bank_t'(r[5]), vaddr_t'(r[31:24] % `NUMVROW));
      end
    end
    drain();
  endtask

  initial begin
    rng_state = 32'hfa4d_eb2f;
    edge_cnt  = 0;
    init_done = 1'b0;
    pend_wr   = 1'b0;
    rst_n     = 1'b0;
    write     = 1'b0;
    wr_bnk    = '0;
    wr_adr    = '0;
    bw        = '0;
    din       = '0;
    read      = 1'b0;
    rd_bnk    = '0;
    rd_adr    = '0;
    for (int b = 0; b < `NUMVBNK; b++) begin
      for (int a = 0; a < `NUMVROW; a++) begin
        model[b][a] = '0;
      end
    end
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    test_init();
    test_round_trip();
    test_partial();
    test_forward();
    test_random();
    if (i_align_mem_top.i_align_props.failed === 1'b1) begin
      abort_run("A concurrent assertion in align_props failed");
    end else begin
      $display("SIMULATION PASSED");
      $finish;
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    abort_run($sformatf("Timeout: the tests did not finish within %0d clock cycles",
                        WATCHDOG_CYCLES));
  end

endmodule

//--- src.f
+incdir+hdl
hdl/align_pkg.sv
hdl/mem_pkg.sv
hdl/mem_if.sv
hdl/np2_addr.sv
hdl/align_bw.sv
hdl/mem_init_ctrl.sv
hdl/banked_sram.sv
hdl/align_mem_top.sv
sim/align_props.sv
sim/align_tb.sv

//--- Makefile
# Verilator build of the word aligner testbench
SIM = obj_dir/Valign_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module align_tb -f src.f -Mdir obj_dir

# Pass or fail is decided by the log alone
run: compile
	$(SIM) +verilator+error+limit+100 | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
